// File: core_input.hex
// instruction  flag  rd  data
// flag 1 expects one write-back record of rd and data, flag 0 expects none
142468a1 1 01 12345000
0399e021 1 01 12345678
02bffc02 1 02 ffffffff
02801403 1 03 00000005
00100c44 1 04 00000004
00110865 1 05 00000006
00120c46 1 06 00000001
00128c47 1 07 00000000
00148828 1 08 12345678
00150c29 1 09 1234567d
00140c2a 1 0a edcba982
0015882b 1 0b edcba987
0017102c 1 0c 23456780
00178c4d 1 0d 07ffffff
00180d4e 1 0e ff6e5d4c
0017046f 1 0f 05000000
0040a030 1 10 34567800
0044f151 1 11 0000000e
0048f152 1 12 fffffffe
023ff473 1 13 00000000
02000054 1 14 00000001
027ffc75 1 15 00000001
037c3c56 1 16 00000f0f
03e00057 1 17 fffff7ff
03aaf018 1 18 00000abc
02a00079 1 19 fffff805
00000000 0 00 00000000
00100c20 1 00 00000000
ffffffff 0 00 00000000
00100c1a 1 1a 00000005
00200000 0 00 00000000
0284001b 1 1b 00000100
0280077c 1 1c 00000101
0010737d 1 1d 00000201
00116fbe 1 1e 00000101
00106f7b 1 1b 00000200
0010737f 1 1f 00000301
001583e1 1 01 00000301
15000002 1 02 80000000
00180443 1 03 c0000000
00178444 1 04 40000000
00121045 1 05 00000001
00129046 1 06 00000000
02801c20 1 00 00000000
00150007 1 07 00000000

// File: int_core.f
core_pkg.sv
reg_file.sv
inst_decode.sv
alu_execute.sv
writeback_stage.sv
int_core_top.sv
tb_checker.sv
tb_int_core.sv

// File: tb_int_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_int_core;

    import core_pkg::*;

    localparam int MAX_ENTRIES = 64;
    localparam int CLK_PERIOD  = 100;
    localparam int READY_LEN   = 2048;
    localparam int DRAIN_LIMIT = 100;

    logic        clk;
    logic        rstn;
    logic        inst_valid;
    inst_word_t  inst;
    logic        inst_ready;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    data_t       wb_data;
    logic        wb_ready;

    // Four words per entry for instruction, flag, rd and data
    logic [31:0] stim_mem [0:4*MAX_ENTRIES-1];
    int          gap_len  [0:MAX_ENTRIES-1];
    bit          ready_pat [0:READY_LEN-1];

    integer      seed;
    logic [31:0] rnd;
    int          num_entries;
    int          limit_cycles;
    int          cycle_cnt;
    int          drain_cnt;
    int          file_errors;
    logic        loaded;

    int          pending;
    int          records;
    int          mismatches;
    int          other_errors;

    int_core_top u_dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .o_inst_ready (inst_ready),
        .o_wb_valid   (wb_valid),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data),
        .i_wb_ready   (wb_ready)
    );

    tb_checker u_check (
        .clk            (clk),
        .rstn           (rstn),
        .i_inst_ready   (inst_ready),
        .i_wb_valid     (wb_valid),
        .i_wb_ready     (wb_ready),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .o_pending      (pending),
        .o_records      (records),
        .o_mismatches   (mismatches),
        .o_other_errors (other_errors)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Output back-pressure
    always @(negedge clk) begin
        if (loaded) begin
            wb_ready = ready_pat[cycle_cnt % READY_LEN];
            cycle_cnt++;
        end
    end

    task automatic make_random_patterns();
        for (int i = 0; i < MAX_ENTRIES; i++) begin
            rnd = $random(seed);
            gap_len[i] = (rnd[1:0] == 2'd0) ? int'(rnd[3:2]) + 1 : 0;
        end
        for (int c = 0; c < READY_LEN; c++) begin
            rnd = $random(seed);
            ready_pat[c] = (rnd[1:0] != 2'd0);
        end
    endtask

    task automatic queue_expected();
        for (int i = 0; i < num_entries; i++) begin
            if (stim_mem[4*i+1][0]) begin
                u_check.add_expected(i, stim_mem[4*i], stim_mem[4*i+2][4:0], stim_mem[4*i+3]);
            end
        end
    endtask

    task automatic send_entry(input int idx);
        repeat (gap_len[idx]) begin
            @(negedge clk);
            inst_valid = 1'b0;
        end
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = stim_mem[4*idx];
        @(posedge clk);
        while (!inst_ready) begin
            @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        wb_ready    = 1'b0;
        loaded      = 1'b0;
        cycle_cnt   = 0;
        file_errors = 0;
        seed        = 32'h460c_b02e;

        $readmemh("core_input.hex", stim_mem);
        num_entries = 0;
        while (num_entries < MAX_ENTRIES && !$isunknown(stim_mem[4*num_entries])) begin
            num_entries++;
        end
        if (num_entries == 0) begin
            $display("Error: no stimulus entries could be read from core_input.hex");
            file_errors++;
        end
        limit_cycles = num_entries * 20 + 100;
        make_random_patterns();
        queue_expected();
        loaded = 1'b1;

        repeat (3) @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            send_entry(i);
        end
        @(negedge clk);
        inst_valid = 1'b0;

        drain_cnt = 0;
        while (pending != 0 && drain_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            drain_cnt++;
        end
        // Room for any stray record after the last one
        repeat (10) @(posedge clk);
        u_check.report_leftover();
        @(negedge clk);

        $display("Done: %0d entries, %0d records, %0d mismatches, %0d other errors",
                 num_entries, records, mismatches, other_errors + file_errors);
        if (mismatches + other_errors + file_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded === 1'b1);
        #(limit_cycles * CLK_PERIOD);
        $display("Error: timeout, the run did not finish within %0d clock periods",
                 limit_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_inst_ready,
    input  logic                i_wb_valid,
    input  logic                i_wb_ready,
    input  core_pkg::reg_addr_t i_wb_rd,
    input  core_pkg::data_t     i_wb_data,
    output int                  o_pending,
    output int                  o_records,
    output int                  o_mismatches,
    output int                  o_other_errors
);

    import core_pkg::*;

    int         exp_entry_q [$];
    inst_word_t exp_inst_q  [$];
    reg_addr_t  exp_rd_q    [$];
    data_t      exp_data_q  [$];

    int         pending = 0;
    int         records = 0;
    int         mismatches = 0;
    int         other_errors = 0;
    int         cur_entry;
    inst_word_t cur_inst;
    reg_addr_t  cur_rd;
    data_t      cur_data;
    logic       exp_ready;

    assign o_pending      = pending;
    assign o_records      = records;
    assign o_mismatches   = mismatches;
    assign o_other_errors = other_errors;

    // Input side stalls only while an output record waits
    assign exp_ready = !(i_wb_valid && !i_wb_ready);

    task automatic add_expected(input int entry, input inst_word_t inst,
                                input reg_addr_t rd, input data_t data);
        exp_entry_q.push_back(entry);
        exp_inst_q.push_back(inst);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        pending++;
    endtask

    task automatic report_leftover();
        if (pending != 0) begin
            $display("Error: %0d expected records never arrived, first missing is entry_%0d",
                     pending, exp_entry_q[0]);
            other_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Record compare, in acceptance order
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rstn && i_inst_ready !== exp_ready) begin
            mismatches++;
            $display("Mismatch inst_ready at %0t: expected %b, actual %b",
                     $time, exp_ready, i_inst_ready);
        end
        if (rstn && i_wb_valid && i_wb_ready) begin
            records++;
            if (pending == 0) begin
                other_errors++;
                $display("Error: a record for r%0d with data %h arrived when none was expected",
                         i_wb_rd, i_wb_data);
            end else begin
                cur_entry = exp_entry_q.pop_front();
                cur_inst  = exp_inst_q.pop_front();
                cur_rd    = exp_rd_q.pop_front();
                cur_data  = exp_data_q.pop_front();
                pending--;
                if (i_wb_rd !== cur_rd || i_wb_data !== cur_data) begin
                    mismatches++;
                    $display("Mismatch entry_%0d (inst %h): expected r%0d = %h, actual r%0d = %h",
                             cur_entry, cur_inst, cur_rd, cur_data, i_wb_rd, i_wb_data);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: int_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module int_core_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_inst_valid,
    input  core_pkg::inst_word_t i_inst,
    output logic                 o_inst_ready,
    output logic                 o_wb_valid,
    output core_pkg::reg_addr_t  o_wb_rd,
    output core_pkg::data_t      o_wb_data,
    input  logic                 i_wb_ready
);

    import core_pkg::*;

    logic      advance;

    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     rs1_data;
    data_t     rs2_data;

    logic      d_valid;
    alu_op_t   d_op;
    reg_addr_t d_rd;
    reg_addr_t d_rs1;
    reg_addr_t d_rs2;
    data_t     d_rs1_data;
    data_t     d_rs2_data;
    data_t     d_imm;
    logic      d_use_imm;

    logic      e_valid;
    reg_addr_t e_rd;
    data_t     e_data;

    logic      w_valid;
    reg_addr_t w_rd;
    data_t     w_data;

    logic      rf_we;
    reg_addr_t rf_waddr;
    data_t     rf_wdata;

    // Any stalled output record freezes all three stages
    assign advance      = ~(w_valid & ~i_wb_ready);
    assign o_inst_ready = advance;
    assign o_wb_valid   = w_valid;
    assign o_wb_rd      = w_rd;
    assign o_wb_data    = w_data;

    inst_decode u_decode (
        .clk          (clk),
        .rstn         (rstn),
        .i_advance    (advance),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_valid      (d_valid),
        .o_op         (d_op),
        .o_rd         (d_rd),
        .o_rs1_q      (d_rs1),
        .o_rs2_q      (d_rs2),
        .o_rs1_data   (d_rs1_data),
        .o_rs2_data   (d_rs2_data),
        .o_imm        (d_imm),
        .o_use_imm    (d_use_imm)
    );

    reg_file u_regs (
        .clk      (clk),
        .i_raddr0 (rs1),
        .i_raddr1 (rs2),
        .o_rdata0 (rs1_data),
        .o_rdata1 (rs2_data),
        .i_we     (rf_we),
        .i_waddr  (rf_waddr),
        .i_wdata  (rf_wdata)
    );

    alu_execute u_execute (
        .clk        (clk),
        .rstn       (rstn),
        .i_advance  (advance),
        .i_valid    (d_valid),
        .i_op       (d_op),
        .i_rd       (d_rd),
        .i_rs1      (d_rs1),
        .i_rs2      (d_rs2),
        .i_rs1_data (d_rs1_data),
        .i_rs2_data (d_rs2_data),
        .i_imm      (d_imm),
        .i_use_imm  (d_use_imm),
        .i_w_valid  (w_valid),
        .i_w_rd     (w_rd),
        .i_w_data   (w_data),
        .o_valid    (e_valid),
        .o_rd       (e_rd),
        .o_data     (e_data)
    );

    writeback_stage u_writeback (
        .clk         (clk),
        .rstn        (rstn),
        .i_advance   (advance),
        .i_valid     (e_valid),
        .i_rd        (e_rd),
        .i_data      (e_data),
        .i_ready_out (i_wb_ready),
        .o_valid     (w_valid),
        .o_rd        (w_rd),
        .o_data      (w_data),
        .o_rf_we     (rf_we),
        .o_rf_waddr  (rf_waddr),
        .o_rf_wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

// File: writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_advance,
    input  logic                i_valid,
    input  core_pkg::reg_addr_t i_rd,
    input  core_pkg::data_t     i_data,
    input  logic                i_ready_out,
    output logic                o_valid,
    output core_pkg::reg_addr_t o_rd,
    output core_pkg::data_t     o_data,
    output logic                o_rf_we,
    output core_pkg::reg_addr_t o_rf_waddr,
    output core_pkg::data_t     o_rf_wdata
);

    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else if (i_advance) begin
            o_valid <= i_valid;
        end
    end

    // Results aimed at r0 are reported as zero
    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_rd   <= i_rd;
            o_data <= (i_rd == reg_addr_t'(0)) ? data_t'(0) : i_data;
        end
    end

    // Commit on the edge the record is taken
    assign o_rf_we    = o_valid & i_ready_out;
    assign o_rf_waddr = o_rd;
    assign o_rf_wdata = o_data;

endmodule

`default_nettype wire

// File: alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_advance,
    input  logic                i_valid,
    input  core_pkg::alu_op_t   i_op,
    input  core_pkg::reg_addr_t i_rd,
    input  core_pkg::reg_addr_t i_rs1,
    input  core_pkg::reg_addr_t i_rs2,
    input  core_pkg::data_t     i_rs1_data,
    input  core_pkg::data_t     i_rs2_data,
    input  core_pkg::data_t     i_imm,
    input  logic                i_use_imm,
    input  logic                i_w_valid,
    input  core_pkg::reg_addr_t i_w_rd,
    input  core_pkg::data_t     i_w_data,
    output logic                o_valid,
    output core_pkg::reg_addr_t o_rd,
    output core_pkg::data_t     o_data
);

    import core_pkg::*;

    data_t    src1;
    data_t    src2;
    data_t    result;
    logic [4:0] shamt;

    // Own output register is the nearest producer, then write-back
    function automatic data_t forward(input reg_addr_t rs, input data_t rf_data);
        data_t val;
        if (rs == '0) begin
            val = '0;
        end else if (o_valid && o_rd == rs) begin
            val = o_data;
        end else if (i_w_valid && i_w_rd == rs) begin
            val = i_w_data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        src1 = forward(i_rs1, i_rs1_data);
        if (i_use_imm) begin
            src2 = i_imm;
        end else begin
            src2 = forward(i_rs2, i_rs2_data);
        end
    end

    assign shamt = src2[4:0];

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'd0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = data_t'($signed(src1) >>> shamt);
            ALU_LUI:  result = i_imm;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else if (i_advance) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_rd   <= i_rd;
            o_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_advance,
    input  logic                 i_inst_valid,
    input  core_pkg::inst_word_t i_inst,
    output core_pkg::reg_addr_t  o_rs1,
    output core_pkg::reg_addr_t  o_rs2,
    input  core_pkg::data_t      i_rs1_data,
    input  core_pkg::data_t      i_rs2_data,
    output logic                 o_valid,
    output core_pkg::alu_op_t    o_op,
    output core_pkg::reg_addr_t  o_rd,
    output core_pkg::reg_addr_t  o_rs1_q,
    output core_pkg::reg_addr_t  o_rs2_q,
    output core_pkg::data_t      o_rs1_data,
    output core_pkg::data_t      o_rs2_data,
    output core_pkg::data_t      o_imm,
    output logic                 o_use_imm
);

    import core_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic        matched;
    alu_op_t     dec_op;
    data_t       dec_imm;
    logic        dec_use_imm;

    assign op17  = i_inst[31:15];
    assign op10  = i_inst[31:22];
    assign op7   = i_inst[31:25];
    assign o_rs1 = i_inst[9:5];
    assign o_rs2 = i_inst[14:10];

    //////////////////////////////////////////////////////////////////////
    // Opcode match and immediate
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        matched     = 1'b1;
        dec_op      = ALU_ADD;
        dec_imm     = '0;
        dec_use_imm = 1'b0;
        case (op17)
            OPC17_ADD:  dec_op = ALU_ADD;
            OPC17_SUB:  dec_op = ALU_SUB;
            OPC17_SLT:  dec_op = ALU_SLT;
            OPC17_SLTU: dec_op = ALU_SLTU;
            OPC17_NOR:  dec_op = ALU_NOR;
            OPC17_AND:  dec_op = ALU_AND;
            OPC17_OR:   dec_op = ALU_OR;
            OPC17_XOR:  dec_op = ALU_XOR;
            OPC17_SLL:  dec_op = ALU_SLL;
            OPC17_SRL:  dec_op = ALU_SRL;
            OPC17_SRA:  dec_op = ALU_SRA;
            OPC17_SLLI, OPC17_SRLI, OPC17_SRAI: begin
                // Shift amount sits in the rk field
                dec_use_imm = 1'b1;
                dec_imm     = {27'd0, i_inst[14:10]};
                if (op17 == OPC17_SLLI) begin
                    dec_op = ALU_SLL;
                end else if (op17 == OPC17_SRLI) begin
                    dec_op = ALU_SRL;
                end else begin
                    dec_op = ALU_SRA;
                end
            end
            default: begin
                dec_use_imm = 1'b1;
                case (op10)
                    OPC10_ADDI, OPC10_SLTI, OPC10_SLTUI: begin
                        dec_imm = {{20{i_inst[21]}}, i_inst[21:10]};
                        if (op10 == OPC10_ADDI) begin
                            dec_op = ALU_ADD;
                        end else if (op10 == OPC10_SLTI) begin
                            dec_op = ALU_SLT;
                        end else begin
                            dec_op = ALU_SLTU;
                        end
                    end
                    OPC10_ANDI: begin
                        dec_op  = ALU_AND;
                        dec_imm = {20'd0, i_inst[21:10]};
                    end
                    OPC10_ORI: begin
                        dec_op  = ALU_OR;
                        dec_imm = {20'd0, i_inst[21:10]};
                    end
                    OPC10_XORI: begin
                        dec_op  = ALU_XOR;
                        dec_imm = {20'd0, i_inst[21:10]};
                    end
                    default: begin
                        dec_op  = ALU_LUI;
                        dec_imm = {i_inst[24:5], 12'd0};
                        matched = (op7 == OPC7_LU12I);
                    end
                endcase
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Decode to execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else if (i_advance) begin
            o_valid <= i_inst_valid & matched;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_op       <= dec_op;
            o_rd       <= i_inst[4:0];
            o_rs1_q    <= o_rs1;
            o_rs2_q    <= o_rs2;
            o_rs1_data <= i_rs1_data;
            o_rs2_data <= i_rs2_data;
            o_imm      <= dec_imm;
            o_use_imm  <= dec_use_imm;
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  core_pkg::reg_addr_t i_raddr0,
    input  core_pkg::reg_addr_t i_raddr1,
    output core_pkg::data_t     o_rdata0,
    output core_pkg::data_t     o_rdata1,
    input  logic                i_we,
    input  core_pkg::reg_addr_t i_waddr,
    input  core_pkg::data_t     i_wdata
);

    import core_pkg::*;

    // Register 0 has no storage
    data_t regs [1:NUM_REGS-1];

    function automatic data_t read_port(input reg_addr_t addr);
        data_t val;
        if (addr == '0) begin
            val = '0;
        end else if (i_we && addr == i_waddr) begin
            val = i_wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        o_rdata0 = read_port(i_raddr0);
        o_rdata1 = read_port(i_raddr1);
    end

    always_ff @(posedge clk) begin
        if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           inst_word_t;
    typedef logic [4:0]            alu_op_t;

    //////////////////////////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////////////////////////

    localparam alu_op_t ALU_ADD  = 5'h00;
    localparam alu_op_t ALU_SUB  = 5'h01;
    localparam alu_op_t ALU_SLT  = 5'h02;
    localparam alu_op_t ALU_SLTU = 5'h03;
    localparam alu_op_t ALU_AND  = 5'h04;
    localparam alu_op_t ALU_OR   = 5'h05;
    localparam alu_op_t ALU_NOR  = 5'h06;
    localparam alu_op_t ALU_XOR  = 5'h07;
    localparam alu_op_t ALU_SLL  = 5'h08;
    localparam alu_op_t ALU_SRL  = 5'h09;
    localparam alu_op_t ALU_SRA  = 5'h0a;
    localparam alu_op_t ALU_LUI  = 5'h0b;

    //////////////////////////////////////////////////////////////////////
    // Opcode patterns
    //////////////////////////////////////////////////////////////////////

    // Register forms and shift by immediate in bits 31:15
    localparam logic [16:0] OPC17_ADD  = 17'h00020;
    localparam logic [16:0] OPC17_SUB  = 17'h00022;
    localparam logic [16:0] OPC17_SLT  = 17'h00024;
    localparam logic [16:0] OPC17_SLTU = 17'h00025;
    localparam logic [16:0] OPC17_NOR  = 17'h00028;
    localparam logic [16:0] OPC17_AND  = 17'h00029;
    localparam logic [16:0] OPC17_OR   = 17'h0002a;
    localparam logic [16:0] OPC17_XOR  = 17'h0002b;
    localparam logic [16:0] OPC17_SLL  = 17'h0002e;
    localparam logic [16:0] OPC17_SRL  = 17'h0002f;
    localparam logic [16:0] OPC17_SRA  = 17'h00030;
    localparam logic [16:0] OPC17_SLLI = 17'h00081;
    localparam logic [16:0] OPC17_SRLI = 17'h00089;
    localparam logic [16:0] OPC17_SRAI = 17'h00091;

    // 12-bit immediate forms in bits 31:22
    localparam logic [9:0] OPC10_SLTI  = 10'h008;
    localparam logic [9:0] OPC10_SLTUI = 10'h009;
    localparam logic [9:0] OPC10_ADDI  = 10'h00a;
    localparam logic [9:0] OPC10_ANDI  = 10'h00d;
    localparam logic [9:0] OPC10_ORI   = 10'h00e;
    localparam logic [9:0] OPC10_XORI  = 10'h00f;

    // Bits 31:25
    localparam logic [6:0] OPC7_LU12I = 7'h0a;

endpackage

`default_nettype wire
